//--- Bender.yml
package:
  name: complex_dot_product

sources:
  - design/dotProductPkg.sv
  - design/sequencerPkg.sv
  - design/operandSelect.sv
  - design/macAccumulator.sv
  - design/dotProductSequencer.sv
  - design/complexDotProduct.sv
  - target: test
    files:
      - testbench/tbComplexDotProduct.sv

//--- design/complexDotProduct.sv
`timescale 1ns/1ps

module complexDotProduct (
	input  logic                      CLK,
	input  logic                      rstN,
	input  logic                      start,
	input  dotProductPkg::cplxVecT    row,
	input  dotProductPkg::cplxVecT    col,
	output dotProductPkg::cplxResultT result,
	output logic                      done,
	output logic                      error,
	output logic                      busy
);

	sequencerPkg::ctrlStepT                     step;    // Control word for this cycle
	logic                                       load;    // Start accepted
	logic signed [dotProductPkg::ElemWidth-1:0] rowPart;
	logic signed [dotProductPkg::ElemWidth-1:0] colPart;
	logic                                       overflow;

	operandSelect i_operandSelect (
		.CLK     (CLK),
		.rstN    (rstN),
		.load    (load),
		.row     (row),
		.col     (col),
		.rowSel  (step.rowSel),
		.colSel  (step.colSel),
		.rowPart (rowPart),
		.colPart (colPart)
	);

	macAccumulator i_macAccumulator (
		.CLK      (CLK),
		.rstN     (rstN),
		.load     (load),
		.step     (step),
		.rowPart  (rowPart),
		.colPart  (colPart),
		.result   (result),
		.overflow (overflow)
	);

	dotProductSequencer i_dotProductSequencer (
		.CLK      (CLK),
		.rstN     (rstN),
		.start    (start),
		.overflow (overflow),
		.step     (step),
		.load     (load),
		.busy     (busy),
		.done     (done),
		.error    (error)
	);

endmodule

//--- design/dotProductPkg.sv
package dotProductPkg;

	////////////////////////////////////////////////////////////
	// Element and accumulator sizes
	////////////////////////////////////////////////////////////

	localparam int ElemWidth = 16;                  // One real or imaginary part
	localparam int VecLen    = 4;                   // Elements per row and column
	localparam int AccWidth  = 32;                  // Accumulator and result part

	////////////////////////////////////////////////////////////
	// Operand formats
	////////////////////////////////////////////////////////////

	// One complex element, real part in the upper half of the word
	typedef struct packed {
		logic signed [ElemWidth-1:0] re;
		logic signed [ElemWidth-1:0] im;
	} cplxElemT;

	// Element 0 sits in the lowest 32 bits
	typedef cplxElemT [VecLen-1:0] cplxVecT;

	////////////////////////////////////////////////////////////
	// Result format
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic signed [AccWidth-1:0] re;         // Sum of re*re - im*im
		logic signed [AccWidth-1:0] im;         // Sum of re*im + im*re
	} cplxResultT;

endpackage

//--- design/dotProductSequencer.sv
`timescale 1ns/1ps

module dotProductSequencer (
	input  logic                   CLK,
	input  logic                   rstN,
	input  logic                   start,
	input  logic                   overflow,
	output sequencerPkg::ctrlStepT step,
	output logic                   load,
	output logic                   busy,
	output logic                   done,
	output logic                   error
);

	sequencerPkg::seqStateT state;
	sequencerPkg::seqStateT nextState;
	logic                   errQ;                   // Outcome latched in the check state
	logic                   ready;                  // Start may be taken this cycle

	// Builds one multiply step for element idx
	function automatic sequencerPkg::ctrlStepT mulStep(
		input logic [1:0] idx,
		input logic       rowIm,
		input logic       colIm,
		input logic       sub
	);
		sequencerPkg::ctrlStepT s;
		s                  = '0;
		s.rowSel.elemIdx   = idx;
		s.rowSel.imagPart  = rowIm;
		s.colSel.elemIdx   = idx;
		s.colSel.imagPart  = colIm;
		s.subtract         = sub;
		s.accEn            = 1'b1;
		return s;
	endfunction

	////////////////////////////////////////////////////////////
	// State register
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state <= sequencerPkg::stIdle;
			errQ  <= 1'b0;
		end else begin
			state <= nextState;
			if (state == sequencerPkg::stCheck) begin
				errQ <= overflow;           // Includes the last imaginary step
			end
		end
	end

	// Linear chain, only idle and finish wait on start
	always_comb begin
		case (state)
			sequencerPkg::stIdle,
			sequencerPkg::stFinish: begin
				nextState = start ? sequencerPkg::stRe0 : sequencerPkg::stIdle;
			end
			default: begin
				nextState = sequencerPkg::seqStateT'(state + 5'd1);
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Step table
	////////////////////////////////////////////////////////////

	always_comb begin
		step = '0;
		case (state)
			sequencerPkg::stRe0:   step = mulStep(2'd0, 1'b0, 1'b0, 1'b0); // + r0*c0
			sequencerPkg::stRe1:   step = mulStep(2'd0, 1'b1, 1'b1, 1'b1); // - i0*i0
			sequencerPkg::stRe2:   step = mulStep(2'd1, 1'b0, 1'b0, 1'b0);
			sequencerPkg::stRe3:   step = mulStep(2'd1, 1'b1, 1'b1, 1'b1);
			sequencerPkg::stRe4:   step = mulStep(2'd2, 1'b0, 1'b0, 1'b0);
			sequencerPkg::stRe5:   step = mulStep(2'd2, 1'b1, 1'b1, 1'b1);
			sequencerPkg::stRe6:   step = mulStep(2'd3, 1'b0, 1'b0, 1'b0);
			sequencerPkg::stRe7:   step = mulStep(2'd3, 1'b1, 1'b1, 1'b1);
			sequencerPkg::stCapRe: step.capReal = 1'b1;
			sequencerPkg::stClr:   step.accClr = 1'b1;
			sequencerPkg::stIm0:   step = mulStep(2'd0, 1'b0, 1'b1, 1'b0); // + r0*ic0
			sequencerPkg::stIm1:   step = mulStep(2'd0, 1'b1, 1'b0, 1'b0); // + i0*rc0
			sequencerPkg::stIm2:   step = mulStep(2'd1, 1'b0, 1'b1, 1'b0);
			sequencerPkg::stIm3:   step = mulStep(2'd1, 1'b1, 1'b0, 1'b0);
			sequencerPkg::stIm4:   step = mulStep(2'd2, 1'b0, 1'b1, 1'b0);
			sequencerPkg::stIm5:   step = mulStep(2'd2, 1'b1, 1'b0, 1'b0);
			sequencerPkg::stIm6:   step = mulStep(2'd3, 1'b0, 1'b1, 1'b0);
			sequencerPkg::stIm7:   step = mulStep(2'd3, 1'b1, 1'b0, 1'b0);
			sequencerPkg::stCapIm: step.capImag = 1'b1;
			default:               step = '0;  // Idle, check and finish
		endcase
	end

	////////////////////////////////////////////////////////////
	// Status outputs
	////////////////////////////////////////////////////////////

	// Busy drops as the done or error pulse appears
	assign ready = (state == sequencerPkg::stIdle) || (state == sequencerPkg::stFinish);
	assign load  = start && ready;
	assign busy  = !ready;
	assign done  = (state == sequencerPkg::stFinish) && !errQ;
	assign error = (state == sequencerPkg::stFinish) && errQ;

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	doneErrorExclusive: assert property (
		@(posedge CLK) disable iff (!rstN)
		!(done && error)
	) else $error("Done and error raised together");

	donePulse: assert property (
		@(posedge CLK) disable iff (!rstN)
		done |=> !done
	) else $error("Done lasted more than one cycle");

	errorPulse: assert property (
		@(posedge CLK) disable iff (!rstN)
		error |=> !error
	) else $error("Error lasted more than one cycle");

	// Every accepted start ends in one outcome strobe after the full chain
	loadEndsInOutcome: assert property (
		@(posedge CLK) disable iff (!rstN)
		load |-> ##21 (done ^ error)
	) else $error("Accepted start not followed by an outcome strobe on time");

endmodule

//--- design/macAccumulator.sv
`timescale 1ns/1ps

module macAccumulator (
	input  logic                                       CLK,
	input  logic                                       rstN,
	input  logic                                       load,
	input  sequencerPkg::ctrlStepT                     step,
	input  logic signed [dotProductPkg::ElemWidth-1:0] rowPart,
	input  logic signed [dotProductPkg::ElemWidth-1:0] colPart,
	output dotProductPkg::cplxResultT                  result,
	output logic                                       overflow
);

	logic signed [2*dotProductPkg::ElemWidth-1:0] product;
	logic signed [dotProductPkg::AccWidth-1:0]    acc;
	logic signed [dotProductPkg::AccWidth:0]      sumWide; // One guard bit
	logic                                         sumOvf;

	////////////////////////////////////////////////////////////
	// Multiply and add/subtract
	////////////////////////////////////////////////////////////

	assign product = rowPart * colPart;             // Full precision signed product

	// Both operands sign extend into the guard bit
	assign sumWide = step.subtract ? (acc - product) : (acc + product);

	// Guard bit differs from the sign bit when the sum leaves the range
	assign sumOvf = sumWide[dotProductPkg::AccWidth] != sumWide[dotProductPkg::AccWidth-1];

	////////////////////////////////////////////////////////////
	// Accumulator and overflow flag
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			acc      <= '0;
			overflow <= 1'b0;
		end else begin
			if (load || step.accClr) begin
				acc <= '0;                  // Start of a new part sum
			end else if (step.accEn) begin
				acc <= sumWide[dotProductPkg::AccWidth-1:0];
			end

			if (load) begin
				overflow <= 1'b0;           // Flag spans both part sums
			end else if (step.accEn && sumOvf) begin
				overflow <= 1'b1;           // Sticky until the next load
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Result registers
	////////////////////////////////////////////////////////////

	// Each half holds until its next capture
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			result <= '0;
		end else begin
			if (step.capReal) begin
				result.re <= acc;
			end
			if (step.capImag) begin
				result.im <= acc;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	accEnClrExclusive: assert property (
		@(posedge CLK) disable iff (!rstN)
		!(step.accEn && step.accClr)
	) else $error("Accumulate and clear issued in the same step");

	captureExclusive: assert property (
		@(posedge CLK) disable iff (!rstN)
		!(step.capReal && step.capImag)
	) else $error("Both result halves captured in the same step");

endmodule

//--- design/operandSelect.sv
`timescale 1ns/1ps

module operandSelect (
	input  logic                                     CLK,
	input  logic                                     rstN,
	input  logic                                     load,
	input  dotProductPkg::cplxVecT                   row,
	input  dotProductPkg::cplxVecT                   col,
	input  sequencerPkg::partSelT                    rowSel,
	input  sequencerPkg::partSelT                    colSel,
	output logic signed [dotProductPkg::ElemWidth-1:0] rowPart,
	output logic signed [dotProductPkg::ElemWidth-1:0] colPart
);

	dotProductPkg::cplxVecT  rowQ;                  // Stored row vector
	dotProductPkg::cplxVecT  colQ;                  // Stored column vector
	dotProductPkg::cplxElemT rowElem;
	dotProductPkg::cplxElemT colElem;

	////////////////////////////////////////////////////////////
	// Operand registers
	////////////////////////////////////////////////////////////

	// Inputs are free to change once the vectors are held here
	always_ff @(posedge CLK) begin
		if (load) begin
			rowQ <= row;
			colQ <= col;
		end
	end

	////////////////////////////////////////////////////////////
	// Part multiplexers
	////////////////////////////////////////////////////////////

	assign rowElem = rowQ[rowSel.elemIdx];          // Element mux
	assign colElem = colQ[colSel.elemIdx];

	assign rowPart = rowSel.imagPart ? rowElem.im : rowElem.re;
	assign colPart = colSel.imagPart ? colElem.im : colElem.re;

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// The sequencer only loads from a no-op step word
	loadWithRealSel: assert property (
		@(posedge CLK) disable iff (!rstN)
		load |-> (!rowSel.imagPart && !colSel.imagPart)
	) else $error("Vector load overlaps an imaginary part select");

endmodule

//--- design/sequencerPkg.sv
package sequencerPkg;

	////////////////////////////////////////////////////////////
	// Control step word
	////////////////////////////////////////////////////////////

	// Picks one scalar out of a stored vector
	typedef struct packed {
		logic [1:0] elemIdx;                    // Element number
		logic       imagPart;                   // 1 selects the imaginary part
	} partSelT;

	// One word per sequencer cycle, all zero means no operation
	typedef struct packed {
		partSelT rowSel;                        // Row operand select
		partSelT colSel;                        // Column operand select
		logic    subtract;                      // Accumulate minus the product
		logic    accEn;                         // Accumulate on this edge
		logic    accClr;                        // Clear the accumulator
		logic    capReal;                       // Copy accumulator to result.re
		logic    capImag;                       // Copy accumulator to result.im
	} ctrlStepT;

	////////////////////////////////////////////////////////////
	// Sequencer states
	////////////////////////////////////////////////////////////

	// Encodings are consecutive so the chain advances by one
	typedef enum logic [4:0] {
		stIdle   = 5'd0,
		stRe0    = 5'd1,  stRe1 = 5'd2,  stRe2 = 5'd3,  stRe3 = 5'd4,
		stRe4    = 5'd5,  stRe5 = 5'd6,  stRe6 = 5'd7,  stRe7 = 5'd8,
		stCapRe  = 5'd9,
		stClr    = 5'd10,
		stIm0    = 5'd11, stIm1 = 5'd12, stIm2 = 5'd13, stIm3 = 5'd14,
		stIm4    = 5'd15, stIm5 = 5'd16, stIm6 = 5'd17, stIm7 = 5'd18,
		stCapIm  = 5'd19,
		stCheck  = 5'd20,
		stFinish = 5'd21
	} seqStateT;

endpackage

//--- filelist.f
design/dotProductPkg.sv
design/sequencerPkg.sv
design/operandSelect.sv
design/macAccumulator.sv
design/dotProductSequencer.sv
design/complexDotProduct.sv
testbench/tbComplexDotProduct.sv

//--- testbench/tbComplexDotProduct.sv
`timescale 1ns/1ps

module tbComplexDotProduct;

	localparam int  ClkHalf         = 10;           // 20 ns period
	localparam int  DriveDelay      = 2;            // Inputs change after the edge
	localparam int  ResetCycles     = 8;
	localparam int  OutcomeLatency  = 21;           // Start edge to done cycle
	localparam int  RunCycles       = 25;           // One run with margin
	localparam int  TimeoutCycles   = 2 * 40 * RunCycles;
	localparam int  RandomRuns      = 20;
	localparam int  IdleCheckCycles = 25;
	localparam longint AccMax = (longint'(1) <<< (dotProductPkg::AccWidth - 1)) - 1;
	localparam longint AccMin = -AccMax - 1;

	logic                      CLK;
	logic                      rstN;
	logic                      start;
	dotProductPkg::cplxVecT    row;
	dotProductPkg::cplxVecT    col;
	dotProductPkg::cplxResultT result;
	logic                      done;
	logic                      error;
	logic                      busy;

	int          cycleCount;                        // Watchdog count
	int          runCycles;                         // Cycles since the start edge
	int          failCount;
	logic [31:0] lfsrState = 32'hc6974049;

	complexDotProduct i_dut (
		.CLK    (CLK),
		.rstN   (rstN),
		.start  (start),
		.row    (row),
		.col    (col),
		.result (result),
		.done   (done),
		.error  (error),
		.busy   (busy)
	);

	initial begin
		CLK = 1'b0;
		forever #ClkHalf CLK = ~CLK;
	end

	////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks
	////////////////////////////////////////////////////////////

	task automatic stopWithFailure();
		$display("Test failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic compareResult(input string name, input dotProductPkg::cplxResultT got,
			input dotProductPkg::cplxResultT exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
			failCount++;
			stopWithFailure();
		end
	endtask

	task automatic compareFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
			failCount++;
			stopWithFailure();
		end
	endtask

	task automatic compareLatency(input string name, input int got, input int exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
			failCount++;
			stopWithFailure();
		end
	endtask

	task automatic compareStep(input string name, input sequencerPkg::ctrlStepT got,
			input sequencerPkg::ctrlStepT exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
			failCount++;
			stopWithFailure();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus helpers and reference model
	////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic nextRandomBit();
		logic fb;
		fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	// Magnitude up to 4095 plus a sign bit
	function automatic logic signed [dotProductPkg::ElemWidth-1:0] randomPart();
		logic [11:0] mag;
		logic        neg;
		for (int b = 0; b < 12; b++) begin
			mag[b] = nextRandomBit();
		end
		neg = nextRandomBit();
		return neg ? -$signed({4'b0, mag}) : $signed({4'b0, mag});
	endfunction

	function automatic dotProductPkg::cplxVecT randomVec();
		dotProductPkg::cplxVecT v;
		for (int i = 0; i < dotProductPkg::VecLen; i++) begin
			v[i].re = randomPart();
			v[i].im = randomPart();
		end
		return v;
	endfunction

	function automatic dotProductPkg::cplxElemT makeElem(input int re, input int im);
		dotProductPkg::cplxElemT e;
		e.re = re[dotProductPkg::ElemWidth-1:0];
		e.im = im[dotProductPkg::ElemWidth-1:0];
		return e;
	endfunction

	function automatic logic outOfRange(input longint v);
		return (v > AccMax) || (v < AccMin);
	endfunction

	// Wide sums in step order, overflow if any partial sum leaves the range
	function automatic void modelDot(input dotProductPkg::cplxVecT r,
			input dotProductPkg::cplxVecT c,
			output dotProductPkg::cplxResultT res, output logic ovf);
		longint acc;
		ovf = 1'b0;
		acc = 0;
		for (int i = 0; i < dotProductPkg::VecLen; i++) begin
			acc = acc + longint'(r[i].re) * longint'(c[i].re);
			ovf = ovf | outOfRange(acc);
			acc = acc - longint'(r[i].im) * longint'(c[i].im);
			ovf = ovf | outOfRange(acc);
		end
		res.re = acc[dotProductPkg::AccWidth-1:0];
		acc = 0;
		for (int i = 0; i < dotProductPkg::VecLen; i++) begin
			acc = acc + longint'(r[i].re) * longint'(c[i].im);
			ovf = ovf | outOfRange(acc);
			acc = acc + longint'(r[i].im) * longint'(c[i].re);
			ovf = ovf | outOfRange(acc);
		end
		res.im = acc[dotProductPkg::AccWidth-1:0];
	endfunction

	////////////////////////////////////////////////////////////
	// Run control
	////////////////////////////////////////////////////////////

	task automatic nextCycle();
		@(posedge CLK);
		#DriveDelay;                            // Outputs settled, inputs may change
	endtask

	task automatic issueStart(input dotProductPkg::cplxVecT r, input dotProductPkg::cplxVecT c);
		row   = r;
		col   = c;
		start = 1'b1;
		nextCycle();                            // Start edge
		start     = 1'b0;
		runCycles = 1;
		compareFlag("busy", busy, 1'b1);
	endtask

	task automatic waitOutcome();
		while (!(done || error)) begin
			nextCycle();
			runCycles++;
		end
	endtask

	task automatic checkOutcome(input dotProductPkg::cplxResultT expRes, input logic expOvf);
		compareLatency("latency", runCycles, OutcomeLatency);
		compareFlag("done", done, !expOvf);
		compareFlag("error", error, expOvf);
		compareFlag("busy", busy, 1'b0);
		compareResult("result", result, expRes);
	endtask

	task automatic runDot(input dotProductPkg::cplxVecT r, input dotProductPkg::cplxVecT c);
		dotProductPkg::cplxResultT expRes;
		logic                      expOvf;
		modelDot(r, c, expRes, expOvf);
		issueStart(r, c);
		waitOutcome();
		checkOutcome(expRes, expOvf);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic checkResetState();
		compareFlag("busy", busy, 1'b0);
		compareFlag("done", done, 1'b0);
		compareFlag("error", error, 1'b0);
		compareResult("result", result, '0);
		compareStep("step", i_dut.step, '0);
	endtask

	task automatic runRealOnly();
		dotProductPkg::cplxVecT r;
		dotProductPkg::cplxVecT c;
		r[0] = makeElem(3, 0);
		r[1] = makeElem(-7, 0);
		r[2] = makeElem(100, 0);
		r[3] = makeElem(2500, 0);
		c[0] = makeElem(12, 0);
		c[1] = makeElem(5, 0);
		c[2] = makeElem(-40, 0);
		c[3] = makeElem(9, 0);
		runDot(r, c);                           // Imaginary sum must come out zero
	endtask

	// Each start lands in the done cycle of the run before
	task automatic runRandomBackToBack();
		for (int n = 0; n < RandomRuns; n++) begin
			runDot(randomVec(), randomVec());
		end
	endtask

	task automatic runStartWhileBusy();
		dotProductPkg::cplxVecT    r;
		dotProductPkg::cplxVecT    c;
		dotProductPkg::cplxResultT expRes;
		logic                      expOvf;
		r = randomVec();
		c = randomVec();
		modelDot(r, c, expRes, expOvf);
		issueStart(r, c);
		repeat (5) begin
			nextCycle();
			runCycles++;
		end
		row   = randomVec();                    // Stored operands must not follow
		col   = randomVec();
		start = 1'b1;
		nextCycle();
		runCycles++;
		start = 1'b0;
		waitOutcome();
		checkOutcome(expRes, expOvf);
		repeat (IdleCheckCycles) begin
			nextCycle();
			compareFlag("done", done, 1'b0);
			compareFlag("error", error, 1'b0);
			compareFlag("busy", busy, 1'b0);
		end
	endtask

	task automatic runOverflowRecovery();
		dotProductPkg::cplxVecT    r;
		dotProductPkg::cplxVecT    c;
		dotProductPkg::cplxResultT expRes;
		logic                      expOvf;
		for (int i = 0; i < dotProductPkg::VecLen; i++) begin
			r[i] = makeElem(-32768, -32768);
			c[i] = makeElem(-32768, 32767);    // Both real terms add
		end
		modelDot(r, c, expRes, expOvf);
		if (!expOvf) begin
			$display("Overflow stimulus stays inside the accumulator range");
			stopWithFailure();
		end
		runDot(r, c);
		runDot(randomVec(), randomVec());
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		failCount = 0;
		rstN      = 1'b0;
		start     = 1'b0;
		row       = '0;
		col       = '0;
		repeat (ResetCycles) nextCycle();
		rstN = 1'b1;
		checkResetState();
		nextCycle();
		runRealOnly();
		runRandomBackToBack();
		runStartWhileBusy();
		runOverflowRecovery();
		nextCycle();
		if (failCount == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			stopWithFailure();
		end
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < TimeoutCycles) begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("Run timed out after %0d cycles without finishing", cycleCount);
		stopWithFailure();
	end

endmodule
